/* fetchPkg.sv */
`default_nettype none

package fetchPkg;

  // Instruction slots per fetch bundle.
  parameter int FETCH_WIDTH = 4;

  typedef logic [31:0] pcT;
  typedef logic [31:0] instT;
  typedef logic [5:0]  opcodeT;

  // Index of one slot within the bundle.
  typedef logic [$clog2(FETCH_WIDTH)-1:0] slotIdxT;

  // Control transfer classes.
  // A conditional branch is the only one that may fall through.
  typedef enum logic [1:0] {
    CT_RET  = 2'd0,
    CT_CALL = 2'd1,
    CT_JUMP = 2'd2,
    CT_COND = 2'd3
  } ctrlTypeE;

  // Opcodes in instruction bits 31..26.
  // Any other value is not a control transfer.
  parameter opcodeT OP_JUMP = 6'h02;
  parameter opcodeT OP_CALL = 6'h03;
  parameter opcodeT OP_COND = 6'h04;
  parameter opcodeT OP_RET  = 6'h05;

endpackage

`default_nettype wire

/* preDecode.sv */
`default_nettype none
`timescale 1ns/1ps

module preDecode import fetchPkg::*;
#(
  parameter int SLOT = 0
)
(
  input  pcT       pc_i,
  input  instT     instruction_i,
  input  pcT       btbTarget_i,
  output pcT       slotPc_o,
  output logic     isCtrl_o,
  output ctrlTypeE ctrlType_o,
  output pcT       target_o
);

  opcodeT opcode;
  pcT     byteOffset;
  pcT     seqPc;

  assign slotPc_o = pc_i + pcT'(4 * SLOT);
  assign seqPc    = slotPc_o + pcT'(4);
  assign opcode   = instruction_i[31:26];

  // Signed word offset scaled to bytes.
  assign byteOffset = {{14{instruction_i[15]}}, instruction_i[15:0], 2'b00};

  always_comb
  begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CT_JUMP;
    target_o   = seqPc + byteOffset;
    case (opcode)
      OP_JUMP: ctrlType_o = CT_JUMP;
      OP_CALL: ctrlType_o = CT_CALL;
      OP_COND: ctrlType_o = CT_COND;
      OP_RET:
      begin
        // Return address comes from the BTB here.
        ctrlType_o = CT_RET;
        target_o   = btbTarget_i;
      end
      default:
      begin
        isCtrl_o = 1'b0;
        target_o = seqPc;
      end
    endcase
  end

endmodule

`default_nettype wire

/* fetchStage2.sv */
`default_nettype none
`timescale 1ns/1ps

module fetchStage2 import fetchPkg::*;
(
  input  logic                       clk,
  input  logic                       rstN_i,
  input  logic [FETCH_WIDTH-1:0]     isCtrl_i,
  input  logic [FETCH_WIDTH-1:0]     prediction_i,
  input  logic [FETCH_WIDTH-1:0]     btbHit_i,
  input  ctrlTypeE [FETCH_WIDTH-1:0] ctrlType_i,
  input  pcT [FETCH_WIDTH-1:0]       slotPc_i,
  input  pcT [FETCH_WIDTH-1:0]       target_i,
  input  pcT                         rasAddr_i,
  input  logic                       stall_i,
  input  logic                       fs1Ready_i,
  input  logic                       ctiQueueFull_i,
  output logic [FETCH_WIDTH-1:0]     instValid_o,
  output logic [FETCH_WIDTH-1:0]     allocVec_o,
  output logic                       allocEn_o,
  output pcT [FETCH_WIDTH-1:0]       slotTarget_o,
  output logic                       flagRecover_o,
  output logic                       flagRtr_o,
  output logic                       flagCall_o,
  output pcT                         redirectTarget_o,
  output pcT                         callPc_o,
  output logic                       fs2Ready_o
);

  logic [FETCH_WIDTH-1:0] redirectVec;
  logic                   found;
  slotIdxT                redirectSlot;
  logic                   rawRecover;

  // Taken prediction, or a transfer that never falls through.
  always_comb
  begin
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      redirectVec[i] = isCtrl_i[i] & (prediction_i[i] | (ctrlType_i[i] != CT_COND));
    end
  end

  // First redirecting slot ends the bundle.
  always_comb
  begin
    found        = 1'b0;
    redirectSlot = slotIdxT'(FETCH_WIDTH - 1);
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      instValid_o[i] = ~found;
      // Not-taken branches ahead of the redirect still need a tag.
      allocVec_o[i]  = ~found & isCtrl_i[i];
      if (!found && redirectVec[i])
      begin
        found        = 1'b1;
        redirectSlot = slotIdxT'(i);
      end
    end
  end

  // Early recovery when the BTB did not know the redirecting transfer.
  always_comb
  begin
    slotTarget_o     = target_i;
    redirectTarget_o = target_i[redirectSlot];
    callPc_o         = slotPc_i[redirectSlot];
    rawRecover       = 1'b0;
    flagRtr_o        = 1'b0;
    flagCall_o       = 1'b0;
    if (found && !btbHit_i[redirectSlot])
    begin
      rawRecover = 1'b1;
      if (ctrlType_i[redirectSlot] == CT_RET)
      begin
        flagRtr_o                  = 1'b1;
        slotTarget_o[redirectSlot] = rasAddr_i;
        redirectTarget_o           = rasAddr_i;
      end
      if (ctrlType_i[redirectSlot] == CT_CALL)
        flagCall_o = 1'b1;
    end
  end

  assign flagRecover_o = rawRecover & ~stall_i & ~ctiQueueFull_i;
  assign allocEn_o     = fs1Ready_i & ~stall_i & ~ctiQueueFull_i;
  assign fs2Ready_o    = fs1Ready_i & ~ctiQueueFull_i;

  // Valid slots form a run from slot 0 with no holes.
  validPrefixA : assert property (
    @(posedge clk) disable iff (!rstN_i)
      instValid_o[0] && ((instValid_o & (instValid_o + 1'b1)) == '0)
  )
  else
    $error("fetchStage2: instValid_o %b is not a prefix", instValid_o);

endmodule

`default_nettype wire

/* ctiQueue.sv */
`default_nettype none
`timescale 1ns/1ps

module ctiQueue import fetchPkg::*;
#(
  parameter int  CTIQ_DEPTH = 8,
  localparam int TAG_W      = $clog2(CTIQ_DEPTH)
)
(
  input  logic                              clk,
  input  logic                              rstN_i,
  input  logic                              allocEn_i,
  input  logic [FETCH_WIDTH-1:0]            allocVec_i,
  input  pcT [FETCH_WIDTH-1:0]              slotPc_i,
  input  pcT [FETCH_WIDTH-1:0]              target_i,
  input  ctrlTypeE [FETCH_WIDTH-1:0]        ctrlType_i,
  output logic [FETCH_WIDTH-1:0][TAG_W-1:0] ctiqTag_o,
  input  logic [TAG_W-1:0]                  ctiQueueIndex_i,
  input  logic                              ctrlVerified_i,
  input  logic                              branchOutcome_i,
  input  pcT                                resolvedTarget_i,
  input  logic                              recoverFlag_i,
  input  logic                              commitCti_i,
  output logic                              ctiQueueFull_o,
  output logic                              updateEn_o,
  output logic                              updateDir_o,
  output pcT                                updatePc_o,
  output pcT                                updateTarget_o,
  output ctrlTypeE                          updateCtrlType_o
);

  typedef logic [TAG_W-1:0] tagT;
  typedef logic [TAG_W:0]   cntT;

  pcT       pcMem     [CTIQ_DEPTH];
  pcT       targetMem [CTIQ_DEPTH];
  ctrlTypeE typeMem   [CTIQ_DEPTH];
  logic     dirMem    [CTIQ_DEPTH];

  tagT  head;
  tagT  tail;
  cntT  count;
  cntT  numAlloc;
  cntT  squashCount;
  cntT  countNext;
  logic allocWrite;

  // Tags follow the tail in slot order.
  always_comb
  begin
    numAlloc = '0;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      ctiqTag_o[i] = tail + numAlloc[TAG_W-1:0];
      numAlloc     = numAlloc + cntT'(allocVec_i[i]);
    end
  end

  // Squash has priority over a same-cycle allocation.
  assign allocWrite  = allocEn_i & ~recoverFlag_i;
  assign squashCount = {1'b0, tagT'(ctiQueueIndex_i - head)} + cntT'(1);

  always_comb
  begin
    if (recoverFlag_i)
      countNext = squashCount;
    else if (allocEn_i)
      countNext = count + numAlloc;
    else
      countNext = count;
    countNext = countNext - cntT'(commitCti_i);
  end

  // Full once a whole bundle might no longer fit.
  assign ctiQueueFull_o = count > cntT'(CTIQ_DEPTH - FETCH_WIDTH);

  always_ff @(posedge clk)
  begin
    if (!rstN_i)
    begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      updateEn_o <= 1'b0;
    end
    else
    begin
      updateEn_o <= commitCti_i;
      count      <= countNext;
      if (commitCti_i)
        head <= head + tagT'(1);
      if (recoverFlag_i)
        tail <= ctiQueueIndex_i + tagT'(1);
      else if (allocEn_i)
        tail <= tail + numAlloc[TAG_W-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      if (allocWrite && allocVec_i[i])
      begin
        pcMem[ctiqTag_o[i]]     <= slotPc_i[i];
        targetMem[ctiqTag_o[i]] <= target_i[i];
        typeMem[ctiqTag_o[i]]   <= ctrlType_i[i];
        dirMem[ctiqTag_o[i]]    <= 1'b0;
      end
    end
    // Execute replaces the predicted target.
    if (ctrlVerified_i)
    begin
      targetMem[ctiQueueIndex_i] <= resolvedTarget_i;
      dirMem[ctiQueueIndex_i]    <= branchOutcome_i;
    end
    if (commitCti_i)
    begin
      updatePc_o       <= pcMem[head];
      updateTarget_o   <= targetMem[head];
      updateCtrlType_o <= typeMem[head];
      updateDir_o      <= dirMem[head] | (typeMem[head] != CT_COND);
    end
  end

  noAllocWhenFullA : assert property (
    @(posedge clk) disable iff (!rstN_i) allocEn_i |-> !ctiQueueFull_o
  )
  else
    $error("ctiQueue: allocation while full, count %0d", count);

  noCommitWhenEmptyA : assert property (
    @(posedge clk) disable iff (!rstN_i) commitCti_i |-> (count != '0)
  )
  else
    $error("ctiQueue: commit while empty");

endmodule

`default_nettype wire

/* fetch2Top.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch2Top import fetchPkg::*;
#(
  parameter int  CTIQ_DEPTH = 8,
  localparam int TAG_W      = $clog2(CTIQ_DEPTH)
)
(
  input  logic                              clk,
  input  logic                              rstN_i,
  input  pcT                                pc_i,
  input  instT [FETCH_WIDTH-1:0]            instructionBundle_i,
  input  logic [FETCH_WIDTH-1:0]            btbHit_i,
  input  logic [FETCH_WIDTH-1:0]            prediction_i,
  input  pcT [FETCH_WIDTH-1:0]              btbTarget_i,
  input  pcT                                rasAddr_i,
  input  logic                              stall_i,
  input  logic                              fs1Ready_i,
  input  logic [TAG_W-1:0]                  ctiQueueIndex_i,
  input  logic                              ctrlVerified_i,
  input  logic                              branchOutcome_i,
  input  pcT                                resolvedTarget_i,
  input  logic                              recoverFlag_i,
  input  logic                              commitCti_i,
  output logic [FETCH_WIDTH-1:0]            instValid_o,
  output instT [FETCH_WIDTH-1:0]            instWord_o,
  output pcT [FETCH_WIDTH-1:0]              instPc_o,
  output pcT [FETCH_WIDTH-1:0]              instTarget_o,
  output logic [FETCH_WIDTH-1:0][TAG_W-1:0] instTag_o,
  output logic [FETCH_WIDTH-1:0]            instPrediction_o,
  output logic                              flagRecover_o,
  output logic                              flagRtr_o,
  output logic                              flagCall_o,
  output pcT                                redirectTarget_o,
  output pcT                                callPc_o,
  output logic                              updateEn_o,
  output logic                              updateDir_o,
  output pcT                                updatePc_o,
  output pcT                                updateTarget_o,
  output ctrlTypeE                          updateCtrlType_o,
  output logic                              fs2Ready_o,
  output logic                              ctiQueueFull_o
);

  pcT [FETCH_WIDTH-1:0]       slotPc;
  pcT [FETCH_WIDTH-1:0]       decTarget;
  ctrlTypeE [FETCH_WIDTH-1:0] ctrlType;
  logic [FETCH_WIDTH-1:0]     isCtrl;
  logic [FETCH_WIDTH-1:0]     allocVec;
  logic                       allocEn;

  assign instPc_o         = slotPc;
  assign instPrediction_o = prediction_i;

  for (genvar i = 0; i < FETCH_WIDTH; i++)
  begin : gSlot
    // Slot 0 sits in the most significant word.
    assign instWord_o[i] = instructionBundle_i[FETCH_WIDTH-1-i];

    preDecode #(
      .SLOT(i)
    ) uPreDecode (
      .pc_i         (pc_i),
      .instruction_i(instructionBundle_i[FETCH_WIDTH-1-i]),
      .btbTarget_i  (btbTarget_i[i]),
      .slotPc_o     (slotPc[i]),
      .isCtrl_o     (isCtrl[i]),
      .ctrlType_o   (ctrlType[i]),
      .target_o     (decTarget[i])
    );
  end

  fetchStage2 uFetchStage2 (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .isCtrl_i        (isCtrl),
    .prediction_i    (prediction_i),
    .btbHit_i        (btbHit_i),
    .ctrlType_i      (ctrlType),
    .slotPc_i        (slotPc),
    .target_i        (decTarget),
    .rasAddr_i       (rasAddr_i),
    .stall_i         (stall_i),
    .fs1Ready_i      (fs1Ready_i),
    .ctiQueueFull_i  (ctiQueueFull_o),
    .instValid_o     (instValid_o),
    .allocVec_o      (allocVec),
    .allocEn_o       (allocEn),
    .slotTarget_o    (instTarget_o),
    .flagRecover_o   (flagRecover_o),
    .flagRtr_o       (flagRtr_o),
    .flagCall_o      (flagCall_o),
    .redirectTarget_o(redirectTarget_o),
    .callPc_o        (callPc_o),
    .fs2Ready_o      (fs2Ready_o)
  );

  ctiQueue #(
    .CTIQ_DEPTH(CTIQ_DEPTH)
  ) uCtiQueue (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .allocEn_i       (allocEn),
    .allocVec_i      (allocVec),
    .slotPc_i        (slotPc),
    .target_i        (instTarget_o),
    .ctrlType_i      (ctrlType),
    .ctiqTag_o       (instTag_o),
    .ctiQueueIndex_i (ctiQueueIndex_i),
    .ctrlVerified_i  (ctrlVerified_i),
    .branchOutcome_i (branchOutcome_i),
    .resolvedTarget_i(resolvedTarget_i),
    .recoverFlag_i   (recoverFlag_i),
    .commitCti_i     (commitCti_i),
    .ctiQueueFull_o  (ctiQueueFull_o),
    .updateEn_o      (updateEn_o),
    .updateDir_o     (updateDir_o),
    .updatePc_o      (updatePc_o),
    .updateTarget_o  (updateTarget_o),
    .updateCtrlType_o(updateCtrlType_o)
  );

endmodule

`default_nettype wire

/* tbFetch2.sv */
`default_nettype none
`timescale 1ns/1ps

module tbFetch2 import fetchPkg::*;
();

  localparam int CTIQ_DEPTH = 8;
  localparam int TAG_W      = $clog2(CTIQ_DEPTH);

  logic                              clk;
  logic                              rstN_i;
  pcT                                pc_i;
  instT [FETCH_WIDTH-1:0]            instructionBundle_i;
  logic [FETCH_WIDTH-1:0]            btbHit_i;
  logic [FETCH_WIDTH-1:0]            prediction_i;
  pcT [FETCH_WIDTH-1:0]              btbTarget_i;
  pcT                                rasAddr_i;
  logic                              stall_i;
  logic                              fs1Ready_i;
  logic [TAG_W-1:0]                  ctiQueueIndex_i;
  logic                              ctrlVerified_i;
  logic                              branchOutcome_i;
  pcT                                resolvedTarget_i;
  logic                              recoverFlag_i;
  logic                              commitCti_i;
  logic [FETCH_WIDTH-1:0]            instValid_o;
  instT [FETCH_WIDTH-1:0]            instWord_o;
  pcT [FETCH_WIDTH-1:0]              instPc_o;
  pcT [FETCH_WIDTH-1:0]              instTarget_o;
  logic [FETCH_WIDTH-1:0][TAG_W-1:0] instTag_o;
  logic [FETCH_WIDTH-1:0]            instPrediction_o;
  logic                              flagRecover_o;
  logic                              flagRtr_o;
  logic                              flagCall_o;
  pcT                                redirectTarget_o;
  pcT                                callPc_o;
  logic                              updateEn_o;
  logic                              updateDir_o;
  pcT                                updatePc_o;
  pcT                                updateTarget_o;
  ctrlTypeE                          updateCtrlType_o;
  logic                              fs2Ready_o;
  logic                              ctiQueueFull_o;

  // Bundle under construction and the queue model.
  opcodeT      opc [FETCH_WIDTH];
  logic [15:0] off [FETCH_WIDTH];
  pcT          mPc [CTIQ_DEPTH];
  pcT          mTgt [CTIQ_DEPTH];
  ctrlTypeE    mType [CTIQ_DEPTH];
  logic        mDir [CTIQ_DEPTH];
  int          mHead;
  int          mTail;
  int          mCount;
  int          errors;
  int          checks;
  int          waited;
  int          idx;
  integer      seed;
  string       testName;

  fetch2Top #(
    .CTIQ_DEPTH(CTIQ_DEPTH)
  ) dut (
    .*
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #50 clk = ~clk;
    end
  end

  stallMaskA : assert property (@(posedge clk) disable iff (!rstN_i) stall_i |-> !flagRecover_o)
  else
  begin
    errors++;
    $display("Error %s stallMask: expected flagRecover_o 0, actual 1", testName);
  end

  fullMaskA : assert property (@(posedge clk) disable iff (!rstN_i)
    ctiQueueFull_o |-> !fs2Ready_o && !flagRecover_o)
  else
  begin
    errors++;
    $display("Error %s fullMask: expected fs2Ready_o 0 flagRecover_o 0, actual %b %b",
             testName, $sampled(fs2Ready_o), $sampled(flagRecover_o));
  end

  updateLatencyA : assert property (@(posedge clk) disable iff (!rstN_i)
    commitCti_i |=> updateEn_o)
  else
  begin
    errors++;
    $display("Error %s updateLatency: expected updateEn_o 1, actual 0", testName);
  end

  task automatic checkVal(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    valueA : assert (actual === expected)
    else
    begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  function automatic logic isCti(int i);
    return opc[i] inside {OP_JUMP, OP_CALL, OP_COND, OP_RET};
  endfunction

  function automatic ctrlTypeE typeOf(int i);
    case (opc[i])
      OP_RET:  return CT_RET;
      OP_CALL: return CT_CALL;
      OP_COND: return CT_COND;
      default: return CT_JUMP;
    endcase
  endfunction

  // First slot that leaves the sequential path, FETCH_WIDTH if none.
  function automatic int redirectSlot();
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      if (isCti(i) && (prediction_i[i] || opc[i] != OP_COND))
        return i;
    end
    return FETCH_WIDTH;
  endfunction

  function automatic pcT pktTarget(int i, int r);
    pcT slotPc;
    slotPc = pc_i + pcT'(4 * i);
    if (opc[i] == OP_RET)
      return (i == r && !btbHit_i[i]) ? rasAddr_i : btbTarget_i[i];
    if (isCti(i))
      return slotPc + 4 + pcT'($signed(off[i]) * 4);
    return slotPc + 4;
  endfunction

  task automatic clearBundle();
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      opc[i]         = 6'h00;
      off[i]         = 16'h0000;
      btbTarget_i[i] = '0;
    end
    btbHit_i     = '0;
    prediction_i = '0;
  endtask

  // Drives the bundle, then checks the decode once it settles.
  task automatic presentBundle();
    for (int i = 0; i < FETCH_WIDTH; i++)
      instructionBundle_i[FETCH_WIDTH-1-i] = {opc[i], 10'h000, off[i]};
    #1;
    checkOutputs();
  endtask

  task automatic checkOutputs();
    int   r;
    int   nAlloc;
    logic full;
    logic raw;
    r      = redirectSlot();
    full   = mCount > CTIQ_DEPTH - FETCH_WIDTH;
    raw    = (r < FETCH_WIDTH) ? !btbHit_i[r] : 1'b0;
    nAlloc = 0;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      checkVal("instValid", i <= r, instValid_o[i]);
      checkVal("instWord", {opc[i], 10'h000, off[i]}, instWord_o[i]);
      checkVal("instPc", pc_i + pcT'(4 * i), instPc_o[i]);
      checkVal("instTarget", pktTarget(i, r), instTarget_o[i]);
      checkVal("instPrediction", prediction_i[i], instPrediction_o[i]);
      if (isCti(i) && i <= r)
      begin
        checkVal("instTag", (mTail + nAlloc) % CTIQ_DEPTH, instTag_o[i]);
        nAlloc++;
      end
    end
    if (r < FETCH_WIDTH)
    begin
      checkVal("redirectTarget", pktTarget(r, r), redirectTarget_o);
      checkVal("callPc", pc_i + pcT'(4 * r), callPc_o);
    end
    checkVal("flagRtr", raw && typeOf(r) == CT_RET, flagRtr_o);
    checkVal("flagCall", raw && typeOf(r) == CT_CALL, flagCall_o);
    checkVal("flagRecover", raw && !stall_i && !full, flagRecover_o);
    checkVal("fs2Ready", fs1Ready_i && !full, fs2Ready_o);
    checkVal("ctiQueueFull", full, ctiQueueFull_o);
  endtask

  // Advances the queue model over one edge and checks the registered update.
  task automatic tick();
    int       r;
    logic     expEn;
    pcT       expPc;
    pcT       expTgt;
    ctrlTypeE expType;
    logic     expDir;
    r     = redirectSlot();
    expEn = commitCti_i;
    if (commitCti_i)
    begin
      expPc   = mPc[mHead];
      expTgt  = mTgt[mHead];
      expType = mType[mHead];
      expDir  = mDir[mHead] || mType[mHead] != CT_COND;
    end
    if (recoverFlag_i)
    begin
      mCount = (int'(ctiQueueIndex_i) - mHead + CTIQ_DEPTH) % CTIQ_DEPTH + 1;
      mTail  = (int'(ctiQueueIndex_i) + 1) % CTIQ_DEPTH;
    end
    else if (fs1Ready_i && !stall_i && mCount <= CTIQ_DEPTH - FETCH_WIDTH)
    begin
      for (int i = 0; i < FETCH_WIDTH; i++)
      begin
        if (isCti(i) && i <= r)
        begin
          mPc[mTail]   = pc_i + pcT'(4 * i);
          mTgt[mTail]  = pktTarget(i, r);
          mType[mTail] = typeOf(i);
          mDir[mTail]  = 1'b0;
          mTail        = (mTail + 1) % CTIQ_DEPTH;
          mCount++;
        end
      end
    end
    if (ctrlVerified_i)
    begin
      mTgt[ctiQueueIndex_i] = resolvedTarget_i;
      mDir[ctiQueueIndex_i] = branchOutcome_i;
    end
    if (commitCti_i)
    begin
      mHead = (mHead + 1) % CTIQ_DEPTH;
      mCount--;
    end
    @(posedge clk);
    #1;
    commitCti_i    = 1'b0;
    ctrlVerified_i = 1'b0;
    recoverFlag_i  = 1'b0;
    checkVal("updateEn", expEn, updateEn_o);
    if (expEn)
    begin
      checkVal("updatePc", expPc, updatePc_o);
      checkVal("updateTarget", expTgt, updateTarget_o);
      checkVal("updateCtrlType", expType, updateCtrlType_o);
      checkVal("updateDir", expDir, updateDir_o);
    end
  endtask

  task automatic drainQueue();
    fs1Ready_i = 1'b0;
    waited     = 0;
    while (mCount > 0 && waited < 2 * CTIQ_DEPTH)
    begin
      commitCti_i = 1'b1;
      tick();
      waited++;
    end
    if (mCount > 0)
    begin
      errors++;
      $display("Timeout in %s: the CTI queue did not drain", testName);
    end
    fs1Ready_i = 1'b1;
  endtask

  task automatic randomBundle();
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      case ($unsigned($random(seed)) % 6)
        0:       opc[i] = 6'h00;
        1:       opc[i] = 6'h11;
        2:       opc[i] = OP_JUMP;
        3:       opc[i] = OP_CALL;
        4:       opc[i] = OP_COND;
        default: opc[i] = OP_RET;
      endcase
      off[i]         = 16'($random(seed));
      btbTarget_i[i] = pcT'($random(seed)) & 32'hffff_fffc;
    end
    pc_i         = pcT'($random(seed)) & 32'hffff_fffc;
    rasAddr_i    = pcT'($random(seed)) & 32'hffff_fffc;
    btbHit_i     = 4'($random(seed));
    prediction_i = 4'($random(seed));
  endtask

  initial
  begin
    seed             = 32'h3064;
    errors           = 0;
    checks           = 0;
    mHead            = 0;
    mTail            = 0;
    mCount           = 0;
    testName         = "reset";
    rstN_i           = 1'b0;
    pc_i             = 32'h0000_1000;
    rasAddr_i        = 32'h0000_8000;
    stall_i          = 1'b0;
    fs1Ready_i       = 1'b1;
    ctiQueueIndex_i  = '0;
    ctrlVerified_i   = 1'b0;
    branchOutcome_i  = 1'b0;
    resolvedTarget_i = '0;
    recoverFlag_i    = 1'b0;
    commitCti_i      = 1'b0;
    clearBundle();
    instructionBundle_i = '0;
    repeat (8) @(posedge clk);
    #1;
    rstN_i = 1'b1;
    checkVal("updateEn", 0, updateEn_o);
    checkVal("ctiQueueFull", 0, ctiQueueFull_o);

    testName = "noCti";
    presentBundle();
    tick();

    // Slot 1 PC 0x1004, offset -8 words.
    testName        = "condMiss";
    opc[1]          = OP_COND;
    off[1]          = 16'hfff8;
    prediction_i[1] = 1'b1;
    presentBundle();
    checkVal("instValidVec", 4'b0011, instValid_o);
    checkVal("flagRecoverHigh", 1, flagRecover_o);
    checkVal("directTarget", 32'h0000_0fe8, redirectTarget_o);
    tick();
    btbHit_i[1] = 1'b1;
    presentBundle();
    checkVal("flagRecoverLow", 0, flagRecover_o);
    tick();

    testName = "retCallMiss";
    clearBundle();
    opc[0]         = OP_RET;
    btbTarget_i[0] = 32'h1234_5670;
    presentBundle();
    checkVal("flagRtrHigh", 1, flagRtr_o);
    checkVal("rasTarget", rasAddr_i, instTarget_o[0]);
    tick();
    clearBundle();
    opc[2] = OP_CALL;
    off[2] = 16'h0010;
    presentBundle();
    checkVal("flagCallHigh", 1, flagCall_o);
    checkVal("callPcSlot2", 32'h0000_1008, callPc_o);
    tick();
    drainQueue();

    testName = "tags";
    clearBundle();
    opc[0]   = OP_COND;
    opc[2]   = OP_JUMP;
    btbHit_i = 4'b1111;
    presentBundle();
    checkVal("consecutiveTag", (mTail + 1) % CTIQ_DEPTH, instTag_o[2]);
    tick();

    // Missed jumps in slot 0 until the queue fills.
    testName = "full";
    clearBundle();
    opc[0] = OP_JUMP;
    waited = 0;
    while (!ctiQueueFull_o && waited < 2 * CTIQ_DEPTH)
    begin
      presentBundle();
      tick();
      waited++;
    end
    if (!ctiQueueFull_o)
    begin
      errors++;
      $display("Timeout in %s: ctiQueueFull_o never rose", testName);
    end
    presentBundle();
    checkVal("fs2ReadyLow", 0, fs2Ready_o);
    checkVal("recoverMaskedFull", 0, flagRecover_o);
    tick();
    drainQueue();

    testName = "stall";
    stall_i  = 1'b1;
    presentBundle();
    checkVal("recoverMaskedStall", 0, flagRecover_o);
    tick();
    stall_i = 1'b0;

    testName = "commit";
    drainQueue();
    clearBundle();
    opc[0]   = OP_COND;
    opc[1]   = OP_CALL;
    btbHit_i = 4'b1111;
    presentBundle();
    tick();
    clearBundle();
    opc[3]   = OP_JUMP;
    btbHit_i = 4'b1111;
    presentBundle();
    tick();
    clearBundle();
    presentBundle();
    for (int k = 0; k < 3; k++)
    begin
      ctrlVerified_i   = 1'b1;
      ctiQueueIndex_i  = TAG_W'((mHead + k) % CTIQ_DEPTH);
      resolvedTarget_i = 32'h0000_4000 + pcT'(16 * k);
      branchOutcome_i  = (k == 0);
      tick();
    end
    drainQueue();

    testName = "squash";
    clearBundle();
    opc[0]   = OP_JUMP;
    btbHit_i = 4'b1111;
    idx      = mTail;
    for (int k = 0; k < 3; k++)
    begin
      presentBundle();
      tick();
    end
    recoverFlag_i   = 1'b1;
    ctiQueueIndex_i = TAG_W'(idx);
    tick();
    presentBundle();
    checkVal("tagAfterSquash", (idx + 1) % CTIQ_DEPTH, instTag_o[0]);
    tick();
    drainQueue();

    testName = "random";
    for (int n = 0; n < 300; n++)
    begin
      randomBundle();
      stall_i    = ($random(seed) & 7) == 0;
      fs1Ready_i = ($random(seed) & 7) != 0;
      if (mCount > 0)
      begin
        ctiQueueIndex_i  = TAG_W'((mHead + $unsigned($random(seed)) % mCount) % CTIQ_DEPTH);
        ctrlVerified_i   = ($random(seed) & 3) == 0;
        branchOutcome_i  = ($random(seed) & 1) != 0;
        resolvedTarget_i = pcT'($random(seed));
        commitCti_i      = ($random(seed) & 1) != 0;
        recoverFlag_i    = ($random(seed) & 15) == 0;
      end
      presentBundle();
      tick();
    end
    stall_i = 1'b0;
    drainQueue();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
fetchPkg.sv
preDecode.sv
fetchStage2.sv
ctiQueue.sv
fetch2Top.sv
tbFetch2.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the fetch stage 2 testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tbFetch2 -f tb.f -o simFetch2
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simFetch2 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "Simulation reported failures"
exit 1
